// ==== Makefile ====
# Verilator build and run of the analog path testbench

TOP       ?= rp_tb
FLIST     ?= sources.f
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "variables: TOP FLIST LOG OBJ_DIR VERILATOR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" $(LOG) || { echo "no pass line in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== hw/rp_adc_front.sv ====
// ADC stream front end
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_adc_front (
  input  logic                adc_clk,
  input  logic                rst_n_i,     // data-path reset
  input  logic                loop_adc_i,  // digital loop from dac
  input  rp_pkg::adc_sample_t adc_dat0_i,
  input  rp_pkg::adc_sample_t adc_dat1_i,
  input  logic                adc_dv_i,
  input  rp_pkg::dac_sample_t dac_sat0_i,  // saturated dac sums
  input  rp_pkg::dac_sample_t dac_sat1_i,
  output rp_pkg::adc_sample_t adc_dat0_o,
  output rp_pkg::adc_sample_t adc_dat1_o,
  output logic                adc_dv_o
);
  import rp_pkg::*;

  adc_sample_t dac_ext0;   // dac sample widened to stream width
  adc_sample_t dac_ext1;
  adc_sample_t loop_dat0;  // scaled loop sample
  adc_sample_t loop_dat1;

  // sign extend, then scale up to adc range
  assign dac_ext0  = adc_sample_t'(dac_sat0_i);
  assign dac_ext1  = adc_sample_t'(dac_sat1_i);
  assign loop_dat0 = dac_ext0 <<< `RP_LOOP_SHIFT;
  assign loop_dat1 = dac_ext1 <<< `RP_LOOP_SHIFT;

  ////////////////////////////////////////////////////////////////////////////
  // stream register, one cycle
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    adc_dat0_o <= loop_adc_i ? loop_dat0 : adc_dat0_i;
    adc_dat1_o <= loop_adc_i ? loop_dat1 : adc_dat1_i;
  end

  // looped data is there every cycle
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      adc_dv_o <= 1'b0;
    end else begin
      adc_dv_o <= loop_adc_i | adc_dv_i;
    end
  end

endmodule

// ==== hw/rp_dac_back.sv ====
// DAC back end
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_dac_back (
  input  logic                adc_clk,
  input  logic                rst_n_i,      // data-path reset
  input  logic                loop_dac_i,   // raw adc straight to pins
  input  rp_pkg::dac_sample_t asg_dat0_i,
  input  rp_pkg::dac_sample_t asg_dat1_i,
  input  rp_pkg::dac_sample_t pid_dat0_i,
  input  rp_pkg::dac_sample_t pid_dat1_i,
  input  rp_pkg::adc_sample_t raw0_i,
  input  rp_pkg::adc_sample_t raw1_i,
  output rp_pkg::dac_sample_t dac_sat0_o,   // to adc loop
  output rp_pkg::dac_sample_t dac_sat1_o,
  output rp_pkg::dac_code_t   dac_code_a_o, // channel 1 pin
  output rp_pkg::dac_code_t   dac_code_b_o  // channel 0 pin
);
  import rp_pkg::*;

  logic signed [`RP_DAC_DW:0] sum0;  // one guard bit
  logic signed [`RP_DAC_DW:0] sum1;
  dac_code_t                  code0_q;
  dac_code_t                  code1_q;

  // clip to 14 bit signed when the guard bit disagrees
  function automatic dac_sample_t sat_f(input logic signed [`RP_DAC_DW:0] s);
    if (s[`RP_DAC_DW] ^ s[`RP_DAC_DW-1]) begin
      return {s[`RP_DAC_DW], {(`RP_DAC_DW-1){~s[`RP_DAC_DW]}}};
    end
    return s[`RP_DAC_DW-1:0];
  endfunction

  // two's complement to offset code, negative slope
  function automatic dac_code_t code_f(input dac_sample_t d);
    return {d[`RP_DAC_DW-1], ~d[`RP_DAC_DW-2:0]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // sum and saturation
  ////////////////////////////////////////////////////////////////////////////

  assign sum0 = asg_dat0_i + pid_dat0_i;
  assign sum1 = asg_dat1_i + pid_dat1_i;

  assign dac_sat0_o = sat_f(sum0);
  assign dac_sat1_o = sat_f(sum1);

  // first stage, code per channel
  always_ff @(posedge adc_clk) begin
    code0_q <= code_f(dac_sat0_o);
    code1_q <= code_f(dac_sat1_o);
  end

  ////////////////////////////////////////////////////////////////////////////
  // pin registers
  ////////////////////////////////////////////////////////////////////////////

  // channels cross over, pin a is channel 1
  always_ff @(posedge adc_clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dac_code_a_o <= '0;
      dac_code_b_o <= '0;
    end else if (loop_dac_i) begin  // top bits of raw adc, one cycle
      dac_code_a_o <= raw1_i[`RP_ADC_DW-1 -: `RP_DAC_DW];
      dac_code_b_o <= raw0_i[`RP_ADC_DW-1 -: `RP_DAC_DW];
    end else begin
      dac_code_a_o <= code1_q;
      dac_code_b_o <= code0_q;
    end
  end

endmodule

// ==== hw/rp_defs.svh ====
// Analog path widths and constants
`ifndef RP_DEFS_SVH
`define RP_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// converter widths
////////////////////////////////////////////////////////////////////////////

`define RP_ADC_DW      16  // adc stream word, signed
`define RP_DAC_DW      14  // dac sample and pin code

// expansion connector, pins per polarity
`define RP_EXP_DW      11

////////////////////////////////////////////////////////////////////////////
// sequencing and loopback
////////////////////////////////////////////////////////////////////////////

`define RP_RST_HOLD    64  // cycles of data-path reset after pll lock
`define RP_LOOP_SHIFT  2   // dac to adc scaling in digital loop

`endif

// ==== hw/rp_exp_mux.sv ====
// Expansion pin mux
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_exp_mux (
  input  logic              daisy_trig_en_i,  // export trigger on n[0]
  input  rp_pkg::trig_src_e trig_src_i,
  input  logic              scope_trig_i,
  input  logic              asg_trig_i,
  input  rp_pkg::exp_bus_t  exp_p_in_i,       // pad inputs
  input  rp_pkg::exp_bus_t  exp_n_in_i,
  input  rp_pkg::exp_bus_t  exp_p_out_i,      // software out values
  input  rp_pkg::exp_bus_t  exp_n_out_i,
  input  rp_pkg::exp_bus_t  exp_p_dir_i,      // 1 drives the pad
  input  rp_pkg::exp_bus_t  exp_n_dir_i,
  output rp_pkg::exp_bus_t  exp_p_o,
  output rp_pkg::exp_bus_t  exp_n_o,
  output rp_pkg::exp_bus_t  exp_p_oe_o,
  output rp_pkg::exp_bus_t  exp_n_oe_o,
  output logic              trig_ext_o        // external trigger in
);
  import rp_pkg::*;

  logic     trig_out;   // selected trigger
  exp_bus_t n_alt;      // alternate function enable per n pin
  exp_bus_t n_alt_dat;

  assign trig_out = (trig_src_i == TRIG_SRC_ASG) ? asg_trig_i : scope_trig_i;

  ////////////////////////////////////////////////////////////////////////////
  // alternate functions
  ////////////////////////////////////////////////////////////////////////////

  // only n[0] has one, the daisy trigger
  assign n_alt     = {{(`RP_EXP_DW-1){1'b0}}, daisy_trig_en_i};
  assign n_alt_dat = {{(`RP_EXP_DW-1){1'b0}}, trig_out};

  // p side is plain gpio
  assign exp_p_o    = exp_p_out_i;
  assign exp_p_oe_o = exp_p_dir_i;

  // alternate pins are always outputs
  assign exp_n_o    = (n_alt & n_alt_dat) | (~n_alt & exp_n_out_i);
  assign exp_n_oe_o = n_alt | exp_n_dir_i;

  // n side input only feeds software readback, outside this block

  // p[0] is the external trigger input
  assign trig_ext_o = exp_p_in_i[0];

endmodule

// ==== hw/rp_pkg.sv ====
// Analog path types
`include "rp_defs.svh"

package rp_pkg;

  // stream samples
  typedef logic signed [`RP_ADC_DW-1:0] adc_sample_t;  // adc word
  typedef logic signed [`RP_DAC_DW-1:0] dac_sample_t;  // asg / pid word

  // converter pin code, offset binary with negative slope
  typedef logic [`RP_DAC_DW-1:0] dac_code_t;

  // one polarity of the expansion connector
  typedef logic [`RP_EXP_DW-1:0] exp_bus_t;

  // which trigger goes out on the daisy pin
  typedef enum logic {
    TRIG_SRC_SCOPE = 1'b0,
    TRIG_SRC_ASG   = 1'b1
  } trig_src_e;

  // post-lock reset sequencer
  typedef enum logic [1:0] {
    RST_WAIT_LOCK = 2'd0,
    RST_HOLD      = 2'd1,
    RST_RUN       = 2'd2
  } rst_state_e;

endpackage

// ==== hw/rp_rst_seq.sv ====
// Post-lock reset sequencer
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_rst_seq (
  input  logic adc_clk,
  input  logic arst_n_i,      // async, active low
  input  logic pll_locked_i,  // from clock generator
  output logic path_rst_n_o   // data-path reset, active low
);
  import rp_pkg::*;

  localparam int CNT_W = $clog2(`RP_RST_HOLD);

  logic [1:0]       sync_q;     // release synchronizer
  logic             rst_sync_n;
  logic             lock_q;     // registered lock
  logic             lock_d;     // lock, one cycle older
  logic             lock_rise;
  rst_state_e       state_q;
  logic [CNT_W-1:0] cnt_q;      // hold cycle counter
  logic             hold_q;     // registered, so the reset net stays clean

  // assert async, release after two clocks
  always_ff @(posedge adc_clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign rst_sync_n = sync_q[1];

  always_ff @(posedge adc_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      lock_q <= 1'b0;
      lock_d <= 1'b0;
    end else begin
      lock_q <= pll_locked_i;
      lock_d <= lock_q;
    end
  end

  assign lock_rise = lock_q & ~lock_d;  // first locked cycle

  ////////////////////////////////////////////////////////////////////////////
  // hold FSM
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_sync_n) begin
    if (!rst_sync_n) begin
      state_q <= RST_WAIT_LOCK;
      cnt_q   <= '0;
      hold_q  <= 1'b0;
    end else begin
      case (state_q)
        RST_WAIT_LOCK: begin
          if (lock_rise) begin     // hold starts next cycle
            state_q <= RST_HOLD;
            cnt_q   <= '0;
            hold_q  <= 1'b1;
          end
        end
        RST_HOLD: begin            // keeps counting even if lock drops
          if (cnt_q == CNT_W'(`RP_RST_HOLD - 1)) begin
            state_q <= RST_RUN;
            hold_q  <= 1'b0;
          end else begin
            cnt_q <= cnt_q + 1'b1;
          end
        end
        RST_RUN: begin
          // lock lost, rearm without a new reset
          if (!lock_q) state_q <= RST_WAIT_LOCK;
        end
        default: begin
          state_q <= RST_WAIT_LOCK;
          hold_q  <= 1'b0;
        end
      endcase
    end
  end

  assign path_rst_n_o = rst_sync_n & ~hold_q;

endmodule

// ==== hw/rp_top.sv ====
// Fast analog path top
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_top (
  input  logic                adc_clk,
  input  logic                arst_n_i,       // board reset, active low
  input  logic                pll_locked_i,
  // adc stream
  input  rp_pkg::adc_sample_t adc_dat0_i,
  input  rp_pkg::adc_sample_t adc_dat1_i,
  input  logic                adc_dv_i,
  output rp_pkg::adc_sample_t adc_dat0_o,
  output rp_pkg::adc_sample_t adc_dat1_o,
  output logic                adc_dv_o,
  // generator and controller samples
  input  rp_pkg::dac_sample_t asg_dat0_i,
  input  rp_pkg::dac_sample_t asg_dat1_i,
  input  rp_pkg::dac_sample_t pid_dat0_i,
  input  rp_pkg::dac_sample_t pid_dat1_i,
  output rp_pkg::dac_code_t   dac_code_a_o,   // channel 1
  output rp_pkg::dac_code_t   dac_code_b_o,   // channel 0
  // configuration
  input  logic                loop_adc_i,
  input  logic                loop_dac_i,
  input  logic                daisy_trig_en_i,
  input  rp_pkg::trig_src_e   trig_src_i,
  // triggers
  input  logic                scope_trig_i,
  input  logic                asg_trig_i,
  // expansion connector, split pads
  input  rp_pkg::exp_bus_t    exp_p_in_i,
  input  rp_pkg::exp_bus_t    exp_n_in_i,
  input  rp_pkg::exp_bus_t    exp_p_out_i,
  input  rp_pkg::exp_bus_t    exp_n_out_i,
  input  rp_pkg::exp_bus_t    exp_p_dir_i,
  input  rp_pkg::exp_bus_t    exp_n_dir_i,
  output rp_pkg::exp_bus_t    exp_p_o,
  output rp_pkg::exp_bus_t    exp_n_o,
  output rp_pkg::exp_bus_t    exp_p_oe_o,
  output rp_pkg::exp_bus_t    exp_n_oe_o,
  output logic                trig_ext_o,
  output logic                path_rst_n_o
);
  import rp_pkg::*;

  logic        path_rst_n;  // data-path reset, active low
  dac_sample_t dac_sat0;    // saturated sums, fed back for adc loop
  dac_sample_t dac_sat1;

  ////////////////////////////////////////////////////////////////////////////
  // reset
  ////////////////////////////////////////////////////////////////////////////

  rp_rst_seq u_rst_seq (
    .adc_clk      (adc_clk),
    .arst_n_i     (arst_n_i),
    .pll_locked_i (pll_locked_i),
    .path_rst_n_o (path_rst_n)
  );

  assign path_rst_n_o = path_rst_n;

  ////////////////////////////////////////////////////////////////////////////
  // adc and dac data path
  ////////////////////////////////////////////////////////////////////////////

  rp_adc_front u_adc_front (
    .adc_clk    (adc_clk),
    .rst_n_i    (path_rst_n),
    .loop_adc_i (loop_adc_i),
    .adc_dat0_i (adc_dat0_i),
    .adc_dat1_i (adc_dat1_i),
    .adc_dv_i   (adc_dv_i),
    .dac_sat0_i (dac_sat0),
    .dac_sat1_i (dac_sat1),
    .adc_dat0_o (adc_dat0_o),
    .adc_dat1_o (adc_dat1_o),
    .adc_dv_o   (adc_dv_o)
  );

  rp_dac_back u_dac_back (
    .adc_clk      (adc_clk),
    .rst_n_i      (path_rst_n),
    .loop_dac_i   (loop_dac_i),
    .asg_dat0_i   (asg_dat0_i),
    .asg_dat1_i   (asg_dat1_i),
    .pid_dat0_i   (pid_dat0_i),
    .pid_dat1_i   (pid_dat1_i),
    .raw0_i       (adc_dat0_i),   // raw adc, before the front end loop
    .raw1_i       (adc_dat1_i),
    .dac_sat0_o   (dac_sat0),
    .dac_sat1_o   (dac_sat1),
    .dac_code_a_o (dac_code_a_o),
    .dac_code_b_o (dac_code_b_o)
  );

  // expansion pins and triggers
  rp_exp_mux u_exp_mux (
    .daisy_trig_en_i (daisy_trig_en_i),
    .trig_src_i      (trig_src_i),
    .scope_trig_i    (scope_trig_i),
    .asg_trig_i      (asg_trig_i),
    .exp_p_in_i      (exp_p_in_i),
    .exp_n_in_i      (exp_n_in_i),
    .exp_p_out_i     (exp_p_out_i),
    .exp_n_out_i     (exp_n_out_i),
    .exp_p_dir_i     (exp_p_dir_i),
    .exp_n_dir_i     (exp_n_dir_i),
    .exp_p_o         (exp_p_o),
    .exp_n_o         (exp_n_o),
    .exp_p_oe_o      (exp_p_oe_o),
    .exp_n_oe_o      (exp_n_oe_o),
    .trig_ext_o      (trig_ext_o)
  );

endmodule

// ==== sources.f ====
+incdir+hw
hw/rp_pkg.sv
hw/rp_rst_seq.sv
hw/rp_adc_front.sv
hw/rp_dac_back.sv
hw/rp_exp_mux.sv
hw/rp_top.sv
tests/rp_clk_gen.sv
tests/rp_assert.sv
tests/rp_tb.sv

// ==== tests/rp_assert.sv ====
// Path reset assertions
`timescale 1ns/1ns

module rp_assert (
  input logic              adc_clk,
  input logic              path_rst_n_i,   // data-path reset, active low
  input logic              adc_dv_i,       // stream valid leaving the dut
  input rp_pkg::dac_code_t dac_code_a_i,
  input rp_pkg::dac_code_t dac_code_b_i
);

  // valid is held low for the whole reset
  adc_dv_low_in_rst: assert property (@(posedge adc_clk) !path_rst_n_i |-> !adc_dv_i)
    else $error("adc_dv_o high while path reset is asserted");

  // both pin registers cleared
  dac_zero_in_rst: assert property (@(posedge adc_clk)
    !path_rst_n_i |-> (dac_code_a_i == '0) && (dac_code_b_i == '0))
    else $error("dac codes not zero while path reset is asserted");

  // first cycle after release still shows no valid
  adc_dv_low_on_release: assert property (@(posedge adc_clk) $rose(path_rst_n_i) |-> !adc_dv_i)
    else $error("adc_dv_o high on the first cycle after path reset");

endmodule

bind rp_top rp_assert u_rp_assert (
  .adc_clk      (adc_clk),
  .path_rst_n_i (path_rst_n),
  .adc_dv_i     (adc_dv_o),
  .dac_code_a_i (dac_code_a_o),
  .dac_code_b_i (dac_code_b_o)
);

// ==== tests/rp_clk_gen.sv ====
// Testbench clock and reset
`timescale 1ns/1ns

module rp_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic adc_clk_o,
  output logic arst_n_o    // board reset, active low
);

  initial begin
    adc_clk_o = 1'b0;
    forever #(PERIOD_NS / 2) adc_clk_o = ~adc_clk_o;
  end

  // two clocks of reset, released just after an edge
  initial begin
    arst_n_o = 1'b0;
    repeat (2) @(posedge adc_clk_o);
    #1 arst_n_o = 1'b1;
  end

endmodule

// ==== tests/rp_tb.sv ====
// Analog path testbench
`timescale 1ns/1ns
`include "rp_defs.svh"

module rp_tb;
  import rp_pkg::*;

  localparam int CLK_PERIOD = 4;
  localparam int DRV_DLY    = 1;    // input drive after rising edge
  localparam int N_SETUP    = 120;  // board reset, lock hold, lock drop
  localparam int N_RAND     = 400;
  localparam int N_LOOP     = 150;
  localparam int N_MIX      = 200;
  localparam int N_DRAIN    = 4;
  localparam int N_TOTAL    = N_SETUP + N_RAND + 2 * N_LOOP + N_MIX + N_DRAIN;
  localparam int MARGIN     = 100;
  localparam logic [31:0] SEED = 32'haabde81b;

  // 14 bit signed limits
  localparam int DAC_MAX = (1 << (`RP_DAC_DW - 1)) - 1;
  localparam int DAC_MIN = -(1 << (`RP_DAC_DW - 1));

  // loop select per phase
  localparam int MODE_NORMAL   = 0;
  localparam int MODE_ADC_LOOP = 1;
  localparam int MODE_DAC_LOOP = 2;
  localparam int MODE_MIX      = 3;

  logic        adc_clk;
  logic        arst_n;
  logic        pll_locked;
  adc_sample_t adc_dat0, adc_dat1;  // stream in
  logic        adc_dv;
  dac_sample_t asg_dat0, asg_dat1;
  dac_sample_t pid_dat0, pid_dat1;
  logic        loop_adc;
  logic        loop_dac;
  logic        daisy_trig_en;
  trig_src_e   trig_src;
  logic        scope_trig;
  logic        asg_trig;
  exp_bus_t    exp_p_in, exp_n_in;
  exp_bus_t    exp_p_out, exp_n_out;
  exp_bus_t    exp_p_dir, exp_n_dir;
  // dut outputs
  adc_sample_t adc_out0, adc_out1;
  logic        adc_dv_out;
  dac_code_t   code_a, code_b;
  exp_bus_t    exp_p, exp_n;
  exp_bus_t    exp_p_oe, exp_n_oe;
  logic        trig_ext;
  logic        path_rst_n;

  logic [31:0] rng_state;
  int          err_cnt = 0;
  int          chk_cnt = 0;
  int          hist = 0;            // cycles since path reset released, max 2
  // model pipeline
  adc_sample_t want_adc0, want_adc1;
  logic        want_dv;
  dac_code_t   stage_a, stage_b;    // first dac register
  dac_code_t   want_pin_a, want_pin_b;

  rp_clk_gen #(.PERIOD_NS(CLK_PERIOD)) u_clk_gen (
    .adc_clk_o (adc_clk),
    .arst_n_o  (arst_n)
  );

  rp_top u_rp_top (
    .adc_clk         (adc_clk),
    .arst_n_i        (arst_n),
    .pll_locked_i    (pll_locked),
    .adc_dat0_i      (adc_dat0),
    .adc_dat1_i      (adc_dat1),
    .adc_dv_i        (adc_dv),
    .adc_dat0_o      (adc_out0),
    .adc_dat1_o      (adc_out1),
    .adc_dv_o        (adc_dv_out),
    .asg_dat0_i      (asg_dat0),
    .asg_dat1_i      (asg_dat1),
    .pid_dat0_i      (pid_dat0),
    .pid_dat1_i      (pid_dat1),
    .dac_code_a_o    (code_a),
    .dac_code_b_o    (code_b),
    .loop_adc_i      (loop_adc),
    .loop_dac_i      (loop_dac),
    .daisy_trig_en_i (daisy_trig_en),
    .trig_src_i      (trig_src),
    .scope_trig_i    (scope_trig),
    .asg_trig_i      (asg_trig),
    .exp_p_in_i      (exp_p_in),
    .exp_n_in_i      (exp_n_in),
    .exp_p_out_i     (exp_p_out),
    .exp_n_out_i     (exp_n_out),
    .exp_p_dir_i     (exp_p_dir),
    .exp_n_dir_i     (exp_n_dir),
    .exp_p_o         (exp_p),
    .exp_n_o         (exp_n),
    .exp_p_oe_o      (exp_p_oe),
    .exp_n_oe_o      (exp_n_oe),
    .trig_ext_o      (trig_ext),
    .path_rst_n_o    (path_rst_n)
  );

  ////////////////////////////////////////////////////////////////////////////
  // random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;  // xorshift32
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  // half the draws sit on a rail, so sums clip often
  function automatic dac_sample_t pick_dac_sample();
    logic [31:0] r;
    r = next_rand();
    case (r[31:30])
      2'd0:    return dac_sample_t'(DAC_MAX);
      2'd1:    return dac_sample_t'(DAC_MIN);
      default: return dac_sample_t'(r[`RP_DAC_DW-1:0]);
    endcase
  endfunction

  function automatic dac_sample_t sum_clip(input dac_sample_t a, input dac_sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > DAC_MAX) s = DAC_MAX;
    else if (s < DAC_MIN) s = DAC_MIN;
    return dac_sample_t'(s);
  endfunction

  // sign bit kept, magnitude bits flipped
  function automatic dac_code_t to_pin_code(input dac_sample_t d);
    return dac_code_t'(d) ^ dac_code_t'(DAC_MAX);
  endfunction

  function automatic adc_sample_t loop_scale(input dac_sample_t d);
    return adc_sample_t'(int'(d) * (1 << `RP_LOOP_SHIFT));
  endfunction

  function automatic dac_code_t raw_top_bits(input adc_sample_t raw);
    return dac_code_t'($unsigned(raw) >> (`RP_ADC_DW - `RP_DAC_DW));
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_adc(input string name, input adc_sample_t got, input adc_sample_t want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("FAILED %0t ns: %s is %0d, expected %0d", $time, name, got, want);
    end
  endtask

  task automatic check_code(input string name, input dac_code_t got, input dac_code_t want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("FAILED %0t ns: %s is 0x%h, expected 0x%h", $time, name, got, want);
    end
  endtask

  task automatic check_exp(input string name, input exp_bus_t got, input exp_bus_t want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("FAILED %0t ns: %s is %b, expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    chk_cnt++;
    if (got !== want) begin
      err_cnt++;
      $display("FAILED %0t ns: %s is %b, expected %b", $time, name, got, want);
    end
  endtask

  task automatic check_count(input string name, input int got, input int want);
    chk_cnt++;
    if (got != want) begin
      err_cnt++;
      $display("FAILED %0t ns: %s is %0d, expected %0d", $time, name, got, want);
    end
  endtask

  // outputs are settled at the falling edge
  always @(negedge adc_clk) begin : model_check
    dac_sample_t s0;
    dac_sample_t s1;
    exp_bus_t    want_n;
    exp_bus_t    want_noe;
    logic        trig;

    if (!path_rst_n) hist = 0;
    else if (hist < 2) hist++;

    if (hist == 2) begin  // previous edge clocked out of reset
      check_adc("adc_dat0_o", adc_out0, want_adc0);
      check_adc("adc_dat1_o", adc_out1, want_adc1);
      check_bit("adc_dv_o", adc_dv_out, want_dv);
      check_code("dac_code_a_o", code_a, want_pin_a);
      check_code("dac_code_b_o", code_b, want_pin_b);
    end

    // expansion mux, combinational
    trig     = (trig_src == TRIG_SRC_ASG) ? asg_trig : scope_trig;
    want_n   = exp_n_out;
    want_noe = exp_n_dir;
    if (daisy_trig_en) begin
      want_n[0]   = trig;
      want_noe[0] = 1'b1;
    end
    check_exp("exp_p_o", exp_p, exp_p_out);
    check_exp("exp_p_oe_o", exp_p_oe, exp_p_dir);
    check_exp("exp_n_o", exp_n, want_n);
    check_exp("exp_n_oe_o", exp_n_oe, want_noe);
    check_bit("trig_ext_o", trig_ext, exp_p_in[0]);

    // what the next rising edge should register
    s0         = sum_clip(asg_dat0, pid_dat0);
    s1         = sum_clip(asg_dat1, pid_dat1);
    want_pin_a = loop_dac ? raw_top_bits(adc_dat1) : stage_a;  // pin a is channel 1
    want_pin_b = loop_dac ? raw_top_bits(adc_dat0) : stage_b;
    stage_a    = to_pin_code(s1);
    stage_b    = to_pin_code(s0);
    want_adc0  = loop_adc ? loop_scale(s0) : adc_dat0;
    want_adc1  = loop_adc ? loop_scale(s1) : adc_dat1;
    want_dv    = loop_adc | adc_dv;
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic drive_random();
    logic [31:0] r;
    r             = next_rand();
    adc_dat0      = adc_sample_t'(next_rand());
    adc_dat1      = adc_sample_t'(next_rand());
    adc_dv        = r[0];
    scope_trig    = r[1];
    asg_trig      = r[2];
    daisy_trig_en = r[3];
    trig_src      = trig_src_e'(r[4]);
    asg_dat0      = pick_dac_sample();
    asg_dat1      = pick_dac_sample();
    pid_dat0      = pick_dac_sample();
    pid_dat1      = pick_dac_sample();
    exp_p_in      = exp_bus_t'(next_rand());
    exp_n_in      = exp_bus_t'(next_rand());
    exp_p_out     = exp_bus_t'(next_rand());
    exp_n_out     = exp_bus_t'(next_rand());
    exp_p_dir     = exp_bus_t'(next_rand());
    exp_n_dir     = exp_bus_t'(next_rand());
  endtask

  task automatic run_phase(input int n, input int mode);
    logic [31:0] r;
    repeat (n) begin
      @(posedge adc_clk);
      #DRV_DLY;
      r        = next_rand();
      loop_adc = (mode == MODE_ADC_LOOP) || (mode == MODE_MIX && r[0]);
      loop_dac = (mode == MODE_DAC_LOOP) || (mode == MODE_MIX && r[1]);
      drive_random();
    end
  endtask

  initial begin : main_seq
    int wait_cycles;
    int low_cycles;

    rng_state     = SEED;
    pll_locked    = 1'b0;
    adc_dat0      = '0;
    adc_dat1      = '0;
    adc_dv        = 1'b0;
    asg_dat0      = '0;
    asg_dat1      = '0;
    pid_dat0      = '0;
    pid_dat1      = '0;
    loop_adc      = 1'b0;
    loop_dac      = 1'b0;
    daisy_trig_en = 1'b0;
    trig_src      = TRIG_SRC_SCOPE;
    scope_trig    = 1'b0;
    asg_trig      = 1'b0;
    exp_p_in      = '0;
    exp_n_in      = '0;
    exp_p_out     = '0;
    exp_n_out     = '0;
    exp_p_dir     = '0;
    exp_n_dir     = '0;

    // board reset through the synchronizer
    repeat (4) @(negedge adc_clk);
    wait_cycles = 0;
    while (!path_rst_n && wait_cycles < 20) begin
      @(negedge adc_clk);
      wait_cycles++;
    end
    if (!path_rst_n) begin
      $display("path reset was never released after the board reset");
      err_cnt++;
    end

    // lock edge starts the hold
    @(posedge adc_clk);
    #DRV_DLY;
    pll_locked = 1'b1;
    adc_dv     = 1'b1;  // stream valid, only the hold keeps adc_dv_o low
    @(negedge adc_clk);
    wait_cycles = 0;
    while (path_rst_n && wait_cycles < 8) begin
      @(negedge adc_clk);
      wait_cycles++;
    end
    if (path_rst_n) begin
      $display("path reset did not follow the pll lock edge");
      err_cnt++;
    end else begin
      low_cycles = 0;
      while (!path_rst_n && low_cycles < 2 * `RP_RST_HOLD) begin
        check_bit("adc_dv_o", adc_dv_out, 1'b0);
        check_code("dac_code_a_o", code_a, '0);
        check_code("dac_code_b_o", code_b, '0);
        low_cycles++;
        @(negedge adc_clk);
      end
      check_count("path_rst_n_o low cycles", low_cycles, `RP_RST_HOLD);
      check_bit("adc_dv_o", adc_dv_out, 1'b0);  // first cycle after release
    end

    // lock loss only rearms, path stays up
    @(posedge adc_clk);
    #DRV_DLY;
    pll_locked = 1'b0;
    repeat (16) begin
      @(negedge adc_clk);
      check_bit("path_rst_n_o", path_rst_n, 1'b1);
    end

    run_phase(N_RAND, MODE_NORMAL);
    run_phase(N_LOOP, MODE_ADC_LOOP);
    run_phase(N_LOOP, MODE_DAC_LOOP);
    run_phase(N_MIX, MODE_MIX);
    run_phase(N_DRAIN, MODE_NORMAL);
    @(negedge adc_clk);

    $display("checks %0d, errors %0d", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin : watchdog
    #((N_TOTAL + MARGIN) * CLK_PERIOD);
    $display("run did not finish within %0d cycles", N_TOTAL + MARGIN);
    $display("TESTS FAILED");
    $finish;
  end

endmodule
